//--- project.f
efifo_pkg.sv
rx_word_if.sv
efifo_csr_if.sv
efifo_drop_ctl.sv
efifo_buffer.sv
efifo_insert_ctl.sv
efifo_csr.sv
efifo_top.sv
tb_efifo.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_efifo
FILELIST  := project.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb_efifo.sv
`timescale 1ns/100ps
`default_nettype none

module tb_efifo;
   import efifo_pkg::*;

   localparam int N_ORDER = 300;    // frames and pairs back to back
   localparam int N_DEL   = 200;    // mostly idle pairs
   localparam int N_INS   = 300;    // words sent between gaps
   localparam int N_OVF   = 40;
   localparam int STIM_CYCLES    = N_ORDER + N_DEL + 2 * N_INS + N_OVF;
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 500;
   localparam int KIND_FRAME = 0;
   localparam int KIND_IDLE  = 1;
   localparam int KIND_PRIM  = 2;

   logic        clk = 1'b0;
   logic        rst_n;
   word_data_t  in_data, out_data;
   lane_flags_t in_flags0, in_flags1, out_flags0, out_flags1;
   logic        in_valid, out_valid;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   wb_adr_t     wb_adr;
   wb_dat_t     wb_dat_w, wb_dat_r;

   logic [31:0] lfsr = 32'h0cd65dd8;
   fifo_entry_t frame_q[$];         // words that must come out in order
   fifo_entry_t pending, out_word;  // pending waits for its successor
   logic        have_pending;
   int          frame_seq, sent, out_count, out_start, errors, checks, cycles;
   wb_dat_t     rd, cnt, st;

   efifo_top dut_i (.clk, .rst_n, .in_data, .in_flags0, .in_flags1, .in_valid, .out_data,
                    .out_flags0, .out_flags1, .out_valid, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
                    .wb_dat_w, .wb_dat_r, .wb_ack);

   always #4 clk = ~clk;   // 8 ns

   // --------------------
   // random and reference
   // --------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   function automatic int unsigned rand_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v    = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   // idle pair or same primitive without cv and no sof in the successor
   function automatic logic is_cc(input fifo_entry_t cur, input fifo_entry_t nxt);
      lane_flags_t both;
      logic        same;
      both = cur.flags0 & cur.flags1;
      same = both[FLAG_IDLE] | both[FLAG_NOS] | both[FLAG_OLS] | both[FLAG_LR] | both[FLAG_LRR];
      return same && !cur.flags0[FLAG_CODE_VIOL] && !cur.flags1[FLAG_CODE_VIOL]
             && !nxt.flags0[FLAG_SOF] && !nxt.flags1[FLAG_SOF];
   endfunction

   // legal cc word data for a lane 1 flag vector
   function automatic word_data_t cc_data_for(input lane_flags_t f1);
      logic [23:0] m;
      word_data_t  d;
      m = '0;
      if (f1[FLAG_NOS])      m = MOD_NOS;
      else if (f1[FLAG_OLS]) m = MOD_OLS;
      else if (f1[FLAG_LR])  m = MOD_LR;
      else if (f1[FLAG_LRR]) m = MOD_LRR;
      if (m == '0) d = {56'h0, TYPE_IDLE_IDLE};
      else         d = {m, 8'h00, m, TYPE_OTHER};   // modifier zero modifier type
      return d;
   endfunction

   function automatic logic is_legal_cc(input fifo_entry_t w);
      lane_flags_t pf;
      logic        ok;
      ok = 1'b0;
      for (int k = FLAG_IDLE; k <= FLAG_LRR; k++) begin
         pf = lane_flags_t'(1 << k);
         if (w.data == cc_data_for(pf) && w.flags0 == pf && w.flags1 == pf) ok = 1'b1;
      end
      return ok;
   endfunction

   // --------------------
   // checks
   // --------------------
   task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      assert (got == exp)
      else begin
         errors++;
         $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else begin
         errors++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   task automatic finish_run();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) $display("all tests passed");
      else $display("tests failed");
      $finish;
   endtask

   // output compare at the falling edge
   always @(negedge clk) begin
      if (rst_n && out_valid) begin
         out_count++;
         out_word = {out_flags1, out_flags0, out_data};
         if (frame_q.size() > 0 && out_word == frame_q[0]) frame_q.delete(0);
         else check_true(is_legal_cc(out_word), $sformatf("unexpected output word 0x%0h",
                                                          out_word));
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("run stopped at the cycle limit of %0d, a test did not finish", cycles);
         errors++;
         finish_run();
      end
   end

   // --------------------
   // drivers
   // --------------------
   task automatic apply_reset();
      @(posedge clk);
      rst_n    <= 1'b0;
      in_valid <= 1'b0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      frame_q.delete();
      have_pending = 1'b0;
      sent         = 0;
      out_start    = out_count;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      dat = wb_dat_r;   // valid with ack
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic send_word(input int kind);
      fifo_entry_t w;
      lane_flags_t pf;
      if (kind == KIND_FRAME) begin
         w.data   = {8'hf0, 24'(frame_seq), 32'(rand_bits(32))};   // unique by seq
         w.flags0 = (rand_bits(3) == 0) ? lane_flags_t'(1 << FLAG_SOF) : '0;
         w.flags1 = '0;
         frame_seq++;
      end else begin
         pf = (kind == KIND_IDLE) ? lane_flags_t'(1 << FLAG_IDLE)
                                  : lane_flags_t'(1 << (FLAG_NOS + rand_bits(2)));
         w.data   = cc_data_for(pf);
         w.flags0 = pf;
         w.flags1 = pf;
      end
      // previous word classified now that its successor is known
      if (have_pending && !is_cc(pending, w)) frame_q.push_back(pending);
      pending      = w;
      have_pending = 1'b1;
      @(posedge clk);
      in_data   <= w.data;
      in_flags0 <= w.flags0;
      in_flags1 <= w.flags1;
      in_valid  <= 1'b1;
      sent++;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic end_stream();
      idle_cycle();
      if (have_pending) frame_q.push_back(pending);   // last word has no successor
      have_pending = 1'b0;
   endtask

   // limits to zero so everything left is read out without inserts
   task automatic drain_fifo();
      wb_dat_t s;
      wb_write(REG_READ_LEVEL, 32'h0);
      wb_write(REG_LOW_LIMIT, 32'h0);
      s = '0;
      while (!s[9]) wb_read(REG_STATUS, s);
      repeat (3) @(posedge clk);   // fifo read plus output register
      check_true(frame_q.size() == 0, "frame words missing from the output");
   endtask

   // --------------------
   // tests
   // --------------------
   initial begin
      rst_n     = 1'b0;
      in_data   = '0;
      in_flags0 = '0;
      in_flags1 = '0;
      in_valid  = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;

      // reset values and register access
      apply_reset();
      @(negedge clk);
      check_true(!out_valid, "out_valid high after reset");
      wb_read(REG_HIGH_LIMIT, rd);
      check_value(rd, 20, "high_limit after reset");
      wb_read(REG_LOW_LIMIT, rd);
      check_value(rd, 10, "low_limit after reset");
      wb_read(REG_READ_LEVEL, rd);
      check_value(rd, 16, "read_level after reset");
      wb_write(REG_HIGH_LIMIT, 32'hffff_ffe5);
      wb_write(REG_LOW_LIMIT, 32'h0000_0147);
      wb_write(REG_READ_LEVEL, 32'h0000_00c9);
      wb_write(REG_COUNTERS, 32'hffff_ffff);   // read only
      wb_write(REG_STATUS, 32'hffff_ffff);
      wb_write(3'd5, 32'hffff_ffff);           // unmapped
      wb_write(3'd7, 32'hffff_ffff);
      wb_read(REG_HIGH_LIMIT, rd);
      check_value(rd, 6'h25, "high_limit readback");
      wb_read(REG_LOW_LIMIT, rd);
      check_value(rd, 6'h07, "low_limit readback");
      wb_read(REG_READ_LEVEL, rd);
      check_value(rd, 6'h09, "read_level readback");
      wb_read(REG_COUNTERS, rd);
      check_value(rd, 0, "counters after ignored write");
      wb_read(REG_STATUS, rd);
      check_value(rd, 32'h200, "status after ignored write");   // empty only
      wb_read(3'd5, rd);
      check_value(rd, 0, "unmapped address");

      // order and integrity
      apply_reset();
      repeat (N_ORDER) send_word((rand_bits(3) < 5) ? KIND_FRAME
                                 : (rand_bits(1) ? KIND_PRIM : KIND_IDLE));
      end_stream();
      drain_fifo();

      // deletion
      apply_reset();
      wb_write(REG_HIGH_LIMIT, 32'd4);
      wb_write(REG_READ_LEVEL, 32'd16);
      repeat (N_DEL) send_word((rand_bits(4) == 0) ? KIND_FRAME : KIND_IDLE);
      end_stream();
      drain_fifo();
      wb_read(REG_COUNTERS, cnt);
      wb_read(REG_STATUS, st);
      check_true(cnt[7:0] != 0, "no word deleted above the high limit");
      check_value(8'(sent - cnt[7:0] - cnt[23:16] - st[5:0]),
                  8'(out_count - out_start - cnt[15:8]), "word conservation");

      // insertion with input valid about 3 of 4 cycles
      apply_reset();
      while (sent < N_INS) begin
         if (rand_bits(2) == 0) idle_cycle();
         else send_word(rand_bits(1) ? KIND_PRIM : KIND_IDLE);
      end
      end_stream();
      drain_fifo();
      wb_read(REG_COUNTERS, cnt);
      check_true(cnt[15:8] != 0, "no word inserted below the low limit");

      // overflow with reads and deletes held off
      apply_reset();
      wb_write(REG_READ_LEVEL, 32'd63);
      wb_write(REG_HIGH_LIMIT, 32'd63);
      repeat (N_OVF) send_word(KIND_FRAME);
      end_stream();
      repeat (5) @(posedge clk);   // write pipe then pulse then counter
      wb_read(REG_COUNTERS, cnt);
      check_value(cnt[23:16], 8, "overflow count");
      wb_read(REG_STATUS, st);
      check_value(st[8], 1'b1, "full flag");
      check_value(st[5:0], 32, "occupancy when full");

      finish_run();
   end

endmodule

`default_nettype wire

//--- efifo_top.sv
`timescale 1ns/100ps
`default_nettype none

module efifo_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  efifo_pkg::word_data_t in_data,
   input  efifo_pkg::lane_flags_t in_flags0,
   input  efifo_pkg::lane_flags_t in_flags1,
   input  logic                  in_valid,
   output efifo_pkg::word_data_t out_data,
   output efifo_pkg::lane_flags_t out_flags0,
   output efifo_pkg::lane_flags_t out_flags1,
   output logic                  out_valid,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  efifo_pkg::wb_adr_t    wb_adr,
   input  efifo_pkg::wb_dat_t    wb_dat_w,
   output efifo_pkg::wb_dat_t    wb_dat_r,
   output logic                  wb_ack
);
   import efifo_pkg::*;

   fifo_cnt_t used;
   logic      full, empty, overflow_pulse, rd_en;

   rx_word_if   in_if  ();
   rx_word_if   wr_if  ();
   rx_word_if   rd_if  ();
   rx_word_if   out_if ();
   efifo_csr_if csr_if ();

   // --------------------
   // port mapping
   // --------------------
   assign in_if.data   = in_data;
   assign in_if.flags0 = in_flags0;
   assign in_if.flags1 = in_flags1;
   assign in_if.valid  = in_valid;

   assign out_data   = out_if.data;
   assign out_flags0 = out_if.flags0;
   assign out_flags1 = out_if.flags1;
   assign out_valid  = out_if.valid;

   efifo_drop_ctl drop_i (.clk, .rst_n, .in_w(in_if), .wr_w(wr_if), .csr(csr_if), .used);

   efifo_buffer buf_i (.clk, .rst_n, .wr_w(wr_if), .rd_en, .rd_w(rd_if), .used, .full,
                       .empty, .overflow_pulse);

   efifo_insert_ctl ins_i (.clk, .rst_n, .rd_w(rd_if), .rd_en, .csr(csr_if), .used, .empty,
                           .out_w(out_if));

   efifo_csr csr_i (.clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
                    .wb_ack, .csr(csr_if), .used, .full, .empty, .overflow_pulse);

endmodule

`default_nettype wire

//--- efifo_csr.sv
`timescale 1ns/100ps
`default_nettype none

module efifo_csr (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  efifo_pkg::wb_adr_t   wb_adr,
   input  efifo_pkg::wb_dat_t   wb_dat_w,
   output efifo_pkg::wb_dat_t   wb_dat_r,
   output logic                 wb_ack,
   efifo_csr_if.csr             csr,
   input  efifo_pkg::fifo_cnt_t used,
   input  logic                 full,
   input  logic                 empty,
   input  logic                 overflow_pulse
);
   import efifo_pkg::*;

   limit_t    high_limit, low_limit, read_level;
   stat_cnt_t del_cnt, ins_cnt, ovf_cnt;
   logic      wb_req;
   wb_dat_t   rd_mux;

   assign wb_req = wb_cyc & wb_stb & ~wb_ack;   // no back to back ack

   // --------------------
   // limits
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         high_limit <= HIGH_LIMIT_RST;
         low_limit  <= LOW_LIMIT_RST;
         read_level <= READ_LEVEL_RST;
      end else if (wb_req && wb_we) begin
         case (wb_adr)
            REG_HIGH_LIMIT: high_limit <= wb_dat_w[5:0];
            REG_LOW_LIMIT:  low_limit  <= wb_dat_w[5:0];
            REG_READ_LEVEL: read_level <= wb_dat_w[5:0];
            default:        ;                         // ro or unmapped
         endcase
      end
   end

   assign csr.high_limit = high_limit;
   assign csr.low_limit  = low_limit;
   assign csr.read_level = read_level;

   // counters, overflow saturates
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         del_cnt <= '0;
         ins_cnt <= '0;
         ovf_cnt <= '0;
      end else begin
         if (csr.delete_pulse) del_cnt <= del_cnt + 1'b1;
         if (csr.insert_pulse) ins_cnt <= ins_cnt + 1'b1;
         if (overflow_pulse && (ovf_cnt != '1)) ovf_cnt <= ovf_cnt + 1'b1;
      end
   end

   // read decode
   always_comb begin
      case (wb_adr)
         REG_HIGH_LIMIT: rd_mux = wb_dat_t'(high_limit);
         REG_LOW_LIMIT:  rd_mux = wb_dat_t'(low_limit);
         REG_READ_LEVEL: rd_mux = wb_dat_t'(read_level);
         REG_COUNTERS:   rd_mux = {8'h00, ovf_cnt, ins_cnt, del_cnt};
         REG_STATUS:     rd_mux = {22'h0, empty, full, 2'b00, used};
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) wb_ack <= 1'b0;
      else        wb_ack <= wb_req;
   end

   always_ff @(posedge clk) begin
      if (wb_req) wb_dat_r <= rd_mux;   // held with ack
   end

endmodule

`default_nettype wire

//--- efifo_insert_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module efifo_insert_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   rx_word_if.snk               rd_w,
   output logic                 rd_en,
   efifo_csr_if.rd              csr,
   input  efifo_pkg::fifo_cnt_t used,
   input  logic                 empty,
   rx_word_if.src               out_w
);
   import efifo_pkg::*;

   read_state_t state;
   logic        lt_low, gt_read;        // registered compares
   logic        rd_cc;
   logic        insert;
   lane_flags_t last_flags1;            // lane 1 of last word read
   word_data_t  cc_data;
   lane_flags_t cc_flags;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lt_low  <= 1'b1;
         gt_read <= 1'b0;
      end else begin
         lt_low  <= (used < csr.low_limit);
         gt_read <= (used > csr.read_level);
      end
   end

   assign rd_cc = rd_w.valid & cc_pair(rd_w.flags0, rd_w.flags1);

   // --------------------
   // read fsm
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= RD_IDLE;
      end else begin
         case (state)
            RD_IDLE:     if (gt_read) state <= RD_READING;
            RD_READING:  if (lt_low) state <= RD_LOW_WAIT;
            RD_LOW_WAIT: begin
               if (!lt_low)    state <= RD_READING;
               else if (rd_cc) state <= RD_INSERT;   // repeat this word
            end
            default:     if (!lt_low) state <= RD_READING;
         endcase
      end
   end

   assign insert           = (state == RD_INSERT);
   assign csr.insert_pulse = insert;
   // hold off reads the cycle a cc word comes back while low
   assign rd_en = ((state == RD_READING) | ((state == RD_LOW_WAIT) & ~rd_cc)) & ~empty;

   always_ff @(posedge clk) begin
      if (rd_w.valid) last_flags1 <= rd_w.flags1;
   end

   // --------------------
   // cc word builder
   // --------------------
   always_comb begin
      cc_data  = {56'h0, TYPE_IDLE_IDLE};   // idle pair by default
      cc_flags = lane_flags_t'(1) << FLAG_IDLE;
      if (last_flags1[FLAG_NOS]) begin
         cc_data  = {MOD_NOS, 8'h00, MOD_NOS, TYPE_OTHER};
         cc_flags = lane_flags_t'(1) << FLAG_NOS;
      end else if (last_flags1[FLAG_OLS]) begin
         cc_data  = {MOD_OLS, 8'h00, MOD_OLS, TYPE_OTHER};
         cc_flags = lane_flags_t'(1) << FLAG_OLS;
      end else if (last_flags1[FLAG_LR]) begin
         cc_data  = {MOD_LR, 8'h00, MOD_LR, TYPE_OTHER};
         cc_flags = lane_flags_t'(1) << FLAG_LR;
      end else if (last_flags1[FLAG_LRR]) begin
         cc_data  = {MOD_LRR, 8'h00, MOD_LRR, TYPE_OTHER};
         cc_flags = lane_flags_t'(1) << FLAG_LRR;
      end
   end

   // output register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) out_w.valid <= 1'b0;
      else        out_w.valid <= rd_w.valid | insert;
   end

   always_ff @(posedge clk) begin
      if (rd_w.valid) begin
         out_w.data   <= rd_w.data;
         out_w.flags0 <= rd_w.flags0;
         out_w.flags1 <= rd_w.flags1;
      end else if (insert) begin
         out_w.data   <= cc_data;
         out_w.flags0 <= cc_flags;
         out_w.flags1 <= cc_flags;
      end
   end

   // fifo read data never overlaps an inserted word
   assert property (@(posedge clk) disable iff (!rst_n) insert |-> !rd_w.valid);

endmodule

`default_nettype wire

//--- efifo_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module efifo_buffer (
   input  logic                  clk,
   input  logic                  rst_n,
   rx_word_if.snk                wr_w,
   input  logic                  rd_en,
   rx_word_if.src                rd_w,      // data one cycle after rd_en
   output efifo_pkg::fifo_cnt_t  used,
   output logic                  full,
   output logic                  empty,
   output logic                  overflow_pulse
);
   import efifo_pkg::*;

   fifo_entry_t        mem [FIFO_DEPTH];
   fifo_entry_t        rd_q;
   logic [FIFO_AW-1:0] wr_ptr, rd_ptr;     // wrap naturally at 32
   logic               do_wr, do_rd;
   logic               rd_valid;

   assign full  = (used == fifo_cnt_t'(FIFO_DEPTH));
   assign empty = (used == '0);
   assign do_wr = wr_w.valid & ~full;      // write into full is lost
   assign do_rd = rd_en & ~empty;

   // ram and registered read
   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= {wr_w.flags1, wr_w.flags0, wr_w.data};
      if (do_rd) rd_q <= mem[rd_ptr];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         used           <= '0;
         rd_valid       <= 1'b0;
         overflow_pulse <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   used <= used + 1'b1;
            2'b01:   used <= used - 1'b1;
            default: used <= used;          // both or neither
         endcase
         rd_valid       <= do_rd;
         overflow_pulse <= wr_w.valid & full;
      end
   end

   assign rd_w.data   = rd_q.data;
   assign rd_w.flags0 = rd_q.flags0;
   assign rd_w.flags1 = rd_q.flags1;
   assign rd_w.valid  = rd_valid;

   // read side must respect empty
   assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);

endmodule

`default_nettype wire

//--- efifo_drop_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module efifo_drop_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   rx_word_if.snk               in_w,    // from decoder
   rx_word_if.src               wr_w,    // fifo write port
   efifo_csr_if.drop            csr,
   input  efifo_pkg::fifo_cnt_t used
);
   import efifo_pkg::*;

   word_data_t  a_data, b_data;
   lane_flags_t a_flags0, a_flags1;
   lane_flags_t b_flags0, b_flags1;
   logic        a_valid, b_valid;
   logic        sof_next;               // lookahead from stage a
   logic        wr_cc;
   logic        del;
   drop_state_t state;

   // --------------------
   // input pipeline
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_valid <= 1'b0;
         b_valid <= 1'b0;
      end else begin
         a_valid <= in_w.valid;
         b_valid <= a_valid;
      end
   end

   always_ff @(posedge clk) begin
      a_data   <= in_w.data;   // stage a
      a_flags0 <= in_w.flags0;
      a_flags1 <= in_w.flags1;
      b_data   <= a_data;      // stage b
      b_flags0 <= a_flags0;
      b_flags1 <= a_flags1;
   end

   // cc word only if the following word is known and is no SOF
   assign sof_next = a_flags0[FLAG_SOF] | a_flags1[FLAG_SOF];
   assign wr_cc    = b_valid & a_valid & ~sof_next & cc_pair(b_flags0, b_flags1);

   // --------------------
   // delete fsm
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= DROP_IDLE;
      end else begin
         case (state)
            DROP_IDLE:  if (used > csr.high_limit) state <= DROP_ARMED;
            DROP_ARMED: if (wr_cc) state <= DROP_WAIT0;   // drop this one
            DROP_WAIT0: state <= DROP_WAIT1;
            default:    state <= DROP_IDLE;
         endcase
      end
   end

   assign del              = (state == DROP_ARMED) & wr_cc;
   assign csr.delete_pulse = del;

   // stage b drives the write
   assign wr_w.data   = b_data;
   assign wr_w.flags0 = b_flags0;
   assign wr_w.flags1 = b_flags1;
   assign wr_w.valid  = b_valid & ~del;   // suppressed word never lands

   // a deleted word is followed by a written word without sof
   assert property (@(posedge clk) disable iff (!rst_n)
      del |=> wr_w.valid && !(wr_w.flags0[FLAG_SOF] | wr_w.flags1[FLAG_SOF]));

endmodule

`default_nettype wire

//--- efifo_csr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface efifo_csr_if;
   import efifo_pkg::*;

   limit_t high_limit;    // delete threshold
   limit_t low_limit;     // insert threshold
   limit_t read_level;    // start of reads
   logic   delete_pulse;  // one word dropped
   logic   insert_pulse;  // one word added

   // register block
   modport csr  (output high_limit, low_limit, read_level,
                 input  delete_pulse, insert_pulse);
   // write side
   modport drop (input high_limit, output delete_pulse);
   // read side
   modport rd   (input low_limit, read_level, output insert_pulse);

endinterface

`default_nettype wire

//--- rx_word_if.sv
`timescale 1ns/100ps
`default_nettype none

interface rx_word_if;
   import efifo_pkg::*;

   word_data_t  data;     // 64b transmission word
   lane_flags_t flags0;   // lane 0 decode flags
   lane_flags_t flags1;   // lane 1 decode flags
   logic        valid;    // word qualifier, no ready

   // producer side
   modport src (output data, flags0, flags1, valid);
   // consumer side
   modport snk (input data, flags0, flags1, valid);

endinterface

`default_nettype wire

//--- efifo_pkg.sv
`default_nettype none

package efifo_pkg;

   // --------------------
   // widths and types
   // --------------------
   typedef logic [63:0] word_data_t;    // one transmission word, two lanes
   typedef logic [7:0]  lane_flags_t;   // decode flags per lane
   typedef logic [5:0]  fifo_cnt_t;     // occupancy 0..32
   typedef logic [5:0]  limit_t;        // threshold regs
   typedef logic [7:0]  stat_cnt_t;
   typedef logic [2:0]  wb_adr_t;
   typedef logic [31:0] wb_dat_t;

   typedef struct packed {
      lane_flags_t flags1;
      lane_flags_t flags0;
      word_data_t  data;
   } fifo_entry_t;                      // 80b ram word

   localparam int FIFO_DEPTH = 32;
   localparam int FIFO_AW    = 5;

   // flag bit positions, bit 7 unused
   localparam int FLAG_IDLE      = 0;
   localparam int FLAG_NOS       = 1;
   localparam int FLAG_OLS       = 2;
   localparam int FLAG_LR        = 3;
   localparam int FLAG_LRR       = 4;
   localparam int FLAG_SOF       = 5;
   localparam int FLAG_CODE_VIOL = 6;

   localparam limit_t HIGH_LIMIT_RST = 6'd20;
   localparam limit_t LOW_LIMIT_RST  = 6'd10;
   localparam limit_t READ_LEVEL_RST = 6'd16;

   typedef enum logic [1:0] {DROP_IDLE, DROP_ARMED, DROP_WAIT0, DROP_WAIT1} drop_state_t;
   typedef enum logic [1:0] {RD_IDLE, RD_READING, RD_LOW_WAIT, RD_INSERT} read_state_t;

   // --------------------
   // clock correction
   // --------------------
   localparam logic [7:0]  TYPE_IDLE_IDLE = 8'h1e;
   localparam logic [7:0]  TYPE_OTHER     = 8'h55;   // ordered set pair
   localparam logic [23:0] MOD_NOS        = 24'h4a_b5_b5;
   localparam logic [23:0] MOD_OLS        = 24'h35_8a_8a;
   localparam logic [23:0] MOD_LR         = 24'h49_d5_d5;
   localparam logic [23:0] MOD_LRR        = 24'h35_b5_b5;

   // register map
   localparam wb_adr_t REG_HIGH_LIMIT = 3'd0;
   localparam wb_adr_t REG_LOW_LIMIT  = 3'd1;
   localparam wb_adr_t REG_READ_LEVEL = 3'd2;
   localparam wb_adr_t REG_COUNTERS   = 3'd3;   // ro
   localparam wb_adr_t REG_STATUS     = 3'd4;   // ro

   // both lanes idle or same primitive, no code violation
   function automatic logic cc_pair(input lane_flags_t f0, input lane_flags_t f1);
      lane_flags_t both;
      both = f0 & f1;
      return !(f0[FLAG_CODE_VIOL] | f1[FLAG_CODE_VIOL]) && (|both[FLAG_LRR:FLAG_IDLE]);
   endfunction

endpackage

`default_nettype wire
